//--- hw/cache_geometry_pkg.sv
package cache_geometry_pkg;

    // line layout, 32 bytes per line
    localparam int LINE_BYTES = 32;
    localparam int OFFSET_BITS = 5;

    // 8 sets, direct mapped
    localparam int INDEX_BITS = 3;
    localparam int NUM_SETS = 2 ** INDEX_BITS;

    localparam int TAG_BITS = 24;

    // offset splits into word select and byte within word
    localparam int WORD_SEL_BITS = 3;
    localparam int BYTE_OFF_BITS = 2;

    typedef struct packed {
        logic [TAG_BITS-1:0]      tag;
        logic [INDEX_BITS-1:0]    index;
        logic [WORD_SEL_BITS-1:0] word_sel;
        logic [BYTE_OFF_BITS-1:0] byte_off;
    } cache_addr_fields_t;

    // same byte address, seen raw or as cache fields
    typedef union packed {
        logic [31:0]        raw;
        cache_addr_fields_t f;
    } cache_addr_t;

endpackage

//--- hw/bus_pkg.sv
package bus_pkg;

    // byte address on both the core and memory side
    localparam int ADDR_W = 32;

    // one whole cache line per memory transfer
    localparam int LINE_W = 256;

    // core side word and byte mask
    localparam int WORD_W = 32;
    localparam int MASK_W = WORD_W / 8;

endpackage

//--- hw/snoop_cache.sv
`timescale 1ns/1ps

module snoop_cache
    import cache_geometry_pkg::*, bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // core side
    input  logic [ADDR_W-1:0] ufp_addr,
    input  logic [MASK_W-1:0] ufp_rmask,
    input  logic [MASK_W-1:0] ufp_wmask,
    input  logic [WORD_W-1:0] ufp_wdata,
    output logic [WORD_W-1:0] ufp_rdata,
    output logic              ufp_resp,

    // memory side, routed through the coherence bus
    output logic [ADDR_W-1:0] dfp_addr,
    output logic              dfp_read,
    output logic              dfp_write,
    output logic [LINE_W-1:0] dfp_wdata,
    input  logic [LINE_W-1:0] dfp_rdata,
    input  logic              dfp_resp,

    // bus ownership and snooping
    output logic              bus_req,
    input  logic              bus_ready,
    input  logic              snoop_inval,
    input  logic [ADDR_W-1:0] snoop_addr
);

    typedef enum logic [2:0] {
        IDLE,
        COMP_TAG,
        ACQUIRE_BUS,
        READ_BUS,
        WRITE_BUS
    } state_t;

    state_t state, next_state;

    // latched request
    cache_addr_t       req_addr;
    logic [MASK_W-1:0] req_wmask;
    logic [WORD_W-1:0] req_wdata;

    // tag, data and valid arrays
    logic [TAG_BITS-1:0] tag_arr [NUM_SETS];
    logic [LINE_W-1:0]   data_arr [NUM_SETS];
    logic [NUM_SETS-1:0] valid;

    // merged line waiting for the write phase
    logic [LINE_W-1:0] line_buf;
    logic [LINE_W-1:0] merged_line;

    // high for the one COMP_TAG cycle after a bus transaction
    logic bus_done;

    cache_addr_t snoop_fields;
    logic        is_write;
    logic        hit;
    logic        snoop_hit;
    logic        finish;
    logic        fill_read;
    logic        fill_write;

    assign snoop_fields.raw = snoop_addr;
    assign is_write = (req_wmask != '0);

    assign hit = valid[req_addr.f.index] && (tag_arr[req_addr.f.index] == req_addr.f.tag);

    assign snoop_hit = snoop_inval && valid[snoop_fields.f.index]
                       && (tag_arr[snoop_fields.f.index] == snoop_fields.f.tag);

    // reads may finish on a local hit, writes only after the bus
    assign finish = bus_done || (!is_write && hit);

    assign fill_read = (state == READ_BUS) && dfp_resp && !is_write;
    assign fill_write = (state == WRITE_BUS) && dfp_resp;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (ufp_rmask != '0 || ufp_wmask != '0) begin
                    next_state = COMP_TAG;
                end
            end
            COMP_TAG: begin
                if (finish) begin
                    next_state = IDLE;
                end else begin
                    next_state = ACQUIRE_BUS;
                end
            end
            ACQUIRE_BUS: begin
                if (bus_ready) begin
                    next_state = READ_BUS;
                end
            end
            READ_BUS: begin
                if (dfp_resp) begin
                    next_state = is_write ? WRITE_BUS : COMP_TAG;
                end
            end
            WRITE_BUS: begin
                if (dfp_resp) begin
                    next_state = COMP_TAG;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // byte merge of the store into the freshly read line
    always_comb begin
        merged_line = dfp_rdata;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if ((b / MASK_W) == int'(req_addr.f.word_sel) && req_wmask[b % MASK_W]) begin
                merged_line[b*8 +: 8] = req_wdata[(b % MASK_W)*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            valid <= '0;
            bus_done <= 1'b0;
        end else begin
            state <= next_state;
            bus_done <= fill_read || fill_write;
            if (fill_read || fill_write) begin
                valid[req_addr.f.index] <= 1'b1;
            end
            // never hits the set being filled, the owner is not snooped
            if (snoop_hit) begin
                valid[snoop_fields.f.index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            req_addr.raw <= ufp_addr;
            req_wmask <= ufp_wmask;
            req_wdata <= ufp_wdata;
        end
        if (state == READ_BUS && dfp_resp) begin
            line_buf <= merged_line;
        end
        if (fill_read) begin
            data_arr[req_addr.f.index] <= dfp_rdata;
            tag_arr[req_addr.f.index] <= req_addr.f.tag;
        end
        if (fill_write) begin
            data_arr[req_addr.f.index] <= line_buf;
            tag_arr[req_addr.f.index] <= req_addr.f.tag;
        end
    end

    assign ufp_resp = (state == COMP_TAG) && finish;
    assign ufp_rdata = data_arr[req_addr.f.index][req_addr.f.word_sel*WORD_W +: WORD_W];

    // line aligned request
    assign dfp_addr = {req_addr.f.tag, req_addr.f.index, {OFFSET_BITS{1'b0}}};
    assign dfp_read = (state == READ_BUS);
    assign dfp_write = (state == WRITE_BUS);
    assign dfp_wdata = line_buf;

    assign bus_req = (state == ACQUIRE_BUS) || (state == READ_BUS) || (state == WRITE_BUS);

endmodule

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
    parameter int NUM_CORES = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_CORES-1:0] bus_req,
    output logic [NUM_CORES-1:0] bus_grant
);

    localparam int PTR_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

    logic [PTR_W-1:0] last_owner;
    logic [PTR_W-1:0] pick_idx;
    logic             pick_valid;
    logic             bus_free;

    // owner dropped its request or nobody holds the bus
    assign bus_free = !(|(bus_req & bus_grant));

    // round robin search starting after the last owner
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx = last_owner;
        for (int off = 1; off <= NUM_CORES; off++) begin
            cand = (int'(last_owner) + off) % NUM_CORES;
            if (!pick_valid && bus_req[cand]) begin
                pick_valid = 1'b1;
                pick_idx = PTR_W'(cand);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus_grant <= '0;
            last_owner <= PTR_W'(NUM_CORES - 1);
        end else if (bus_free) begin
            bus_grant <= '0;
            if (pick_valid) begin
                bus_grant[pick_idx] <= 1'b1;
                last_owner <= pick_idx;
            end
        end
    end

endmodule

//--- hw/coherence_bus.sv
`timescale 1ns/1ps

module coherence_bus
    import cache_geometry_pkg::*, bus_pkg::*;
#(
    parameter int NUM_CORES = 4
) (
    input  logic [NUM_CORES-1:0] bus_grant,

    // cache side
    input  logic [ADDR_W-1:0]    cache_dfp_addr [NUM_CORES],
    input  logic [NUM_CORES-1:0] cache_dfp_read,
    input  logic [NUM_CORES-1:0] cache_dfp_write,
    input  logic [LINE_W-1:0]    cache_dfp_wdata [NUM_CORES],
    output logic [LINE_W-1:0]    cache_dfp_rdata,
    output logic [NUM_CORES-1:0] cache_dfp_resp,

    // memory side
    output logic [ADDR_W-1:0]    mem_addr,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic [LINE_W-1:0]    mem_wdata,
    input  logic [LINE_W-1:0]    mem_rdata,
    input  logic                 mem_resp,

    // snoop broadcast
    output logic [ADDR_W-1:0]    snoop_addr,
    output logic [NUM_CORES-1:0] snoop_inval
);

    logic [ADDR_W-1:0] sel_addr;

    // one hot select of the owner's address and line
    always_comb begin
        sel_addr = '0;
        mem_wdata = '0;
        for (int i = 0; i < NUM_CORES; i++) begin
            if (bus_grant[i]) begin
                sel_addr = cache_dfp_addr[i];
                mem_wdata = cache_dfp_wdata[i];
            end
        end
    end

    assign mem_addr = {sel_addr[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign mem_read = |(bus_grant & cache_dfp_read);
    assign mem_write = |(bus_grant & cache_dfp_write);

    // read data is shared, only the owner sees a response
    assign cache_dfp_rdata = mem_rdata;
    assign cache_dfp_resp = bus_grant & {NUM_CORES{mem_resp}};

    // a finished line write kills the copies in every other cache
    assign snoop_addr = mem_addr;
    assign snoop_inval = ~bus_grant & {NUM_CORES{mem_resp && mem_write}};

endmodule

//--- hw/snoop_system_top.sv
`timescale 1ns/1ps

module snoop_system_top
    import bus_pkg::*;
#(
    parameter int NUM_CORES = 4
) (
    input  logic                 clk,
    input  logic                 rst,

    // processor ports
    input  logic [ADDR_W-1:0]    core_addr [NUM_CORES],
    input  logic [MASK_W-1:0]    core_rmask [NUM_CORES],
    input  logic [MASK_W-1:0]    core_wmask [NUM_CORES],
    input  logic [WORD_W-1:0]    core_wdata [NUM_CORES],
    output logic [WORD_W-1:0]    core_rdata [NUM_CORES],
    output logic [NUM_CORES-1:0] core_resp,

    // main memory port
    output logic [ADDR_W-1:0]    mem_addr,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic [LINE_W-1:0]    mem_wdata,
    input  logic [LINE_W-1:0]    mem_rdata,
    input  logic                 mem_resp
);

    logic [NUM_CORES-1:0] bus_req;
    logic [NUM_CORES-1:0] bus_grant;

    logic [ADDR_W-1:0]    cache_dfp_addr [NUM_CORES];
    logic [NUM_CORES-1:0] cache_dfp_read;
    logic [NUM_CORES-1:0] cache_dfp_write;
    logic [LINE_W-1:0]    cache_dfp_wdata [NUM_CORES];
    logic [LINE_W-1:0]    cache_dfp_rdata;
    logic [NUM_CORES-1:0] cache_dfp_resp;

    logic [ADDR_W-1:0]    snoop_addr;
    logic [NUM_CORES-1:0] snoop_inval;

    bus_arbiter #(
        .NUM_CORES(NUM_CORES)
    ) u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .bus_req  (bus_req),
        .bus_grant(bus_grant)
    );

    // one cache per core
    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
        snoop_cache u_cache (
            .clk        (clk),
            .rst        (rst),
            .ufp_addr   (core_addr[i]),
            .ufp_rmask  (core_rmask[i]),
            .ufp_wmask  (core_wmask[i]),
            .ufp_wdata  (core_wdata[i]),
            .ufp_rdata  (core_rdata[i]),
            .ufp_resp   (core_resp[i]),
            .dfp_addr   (cache_dfp_addr[i]),
            .dfp_read   (cache_dfp_read[i]),
            .dfp_write  (cache_dfp_write[i]),
            .dfp_wdata  (cache_dfp_wdata[i]),
            .dfp_rdata  (cache_dfp_rdata),
            .dfp_resp   (cache_dfp_resp[i]),
            .bus_req    (bus_req[i]),
            .bus_ready  (bus_grant[i]),
            .snoop_inval(snoop_inval[i]),
            .snoop_addr (snoop_addr)
        );
    end

    coherence_bus #(
        .NUM_CORES(NUM_CORES)
    ) u_bus (
        .bus_grant      (bus_grant),
        .cache_dfp_addr (cache_dfp_addr),
        .cache_dfp_read (cache_dfp_read),
        .cache_dfp_write(cache_dfp_write),
        .cache_dfp_wdata(cache_dfp_wdata),
        .cache_dfp_rdata(cache_dfp_rdata),
        .cache_dfp_resp (cache_dfp_resp),
        .mem_addr       (mem_addr),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_resp       (mem_resp),
        .snoop_addr     (snoop_addr),
        .snoop_inval    (snoop_inval)
    );

endmodule

//--- bench/line_memory_model.sv
`timescale 1ns/1ps

module line_memory_model
    import bus_pkg::*;
#(
    parameter int MEM_BYTES = 4096
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic [LINE_W-1:0] mem_wdata,
    output logic [LINE_W-1:0] mem_rdata,
    output logic              mem_resp
);

    localparam int LINE_BYTES = LINE_W / 8;

    logic [7:0] mem [MEM_BYTES];
    logic       busy;
    int         wait_cnt;

    // power-up contents, every address bit shows up in its byte
    function automatic logic [7:0] fill_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_resp <= 1'b0;
            mem_rdata <= '0;
            busy <= 1'b0;
            wait_cnt <= 0;
            for (int a = 0; a < MEM_BYTES; a++) begin
                mem[a] <= fill_byte(12'(a));
            end
        end else begin
            mem_resp <= 1'b0;
            if ((mem_read || mem_write) && !mem_resp) begin
                if (!busy) begin
                    // 1 to 4 wait cycles before the response
                    busy <= 1'b1;
                    wait_cnt <= $urandom_range(3, 0);
                end else if (wait_cnt != 0) begin
                    wait_cnt <= wait_cnt - 1;
                end else begin
                    busy <= 1'b0;
                    mem_resp <= 1'b1;
                    for (int k = 0; k < LINE_BYTES; k++) begin
                        if (mem_write) begin
                            mem[{mem_addr[11:5], 5'(k)}] <= mem_wdata[k*8 +: 8];
                        end else begin
                            mem_rdata[k*8 +: 8] <= mem[{mem_addr[11:5], 5'(k)}];
                        end
                    end
                end
            end
        end
    end

endmodule

//--- bench/snoop_system_tb.sv
`timescale 1ns/1ps

module snoop_system_tb
    import bus_pkg::*, cache_geometry_pkg::*;
();

    localparam int NUM_CORES = 4;
    localparam int MEM_BYTES = 4096;
    localparam int WAIT_LIMIT = 200;
    localparam int RANDOM_OPS = 80;

    logic                 clk;
    logic                 rst;
    logic [ADDR_W-1:0]    core_addr [NUM_CORES];
    logic [MASK_W-1:0]    core_rmask [NUM_CORES];
    logic [MASK_W-1:0]    core_wmask [NUM_CORES];
    logic [WORD_W-1:0]    core_wdata [NUM_CORES];
    logic [WORD_W-1:0]    core_rdata [NUM_CORES];
    logic [NUM_CORES-1:0] core_resp;
    logic [ADDR_W-1:0]    mem_addr;
    logic                 mem_read;
    logic                 mem_write;
    logic [LINE_W-1:0]    mem_wdata;
    logic [LINE_W-1:0]    mem_rdata;
    logic                 mem_resp;

    // reference memory, updated at each write's response
    logic [7:0]        ref_mem [MEM_BYTES];
    logic [WORD_W-1:0] exp_word [NUM_CORES];
    logic [WORD_W-1:0] rd_bits [NUM_CORES];
    logic [LINE_W-1:0] exp_line;
    logic [ADDR_W-1:0] exp_addr;
    int                rd_count;
    int                wr_count;

    snoop_system_top #(.NUM_CORES(NUM_CORES)) UUT (.*);

    line_memory_model #(.MEM_BYTES(MEM_BYTES)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first failure");
    endtask

    function automatic logic [7:0] init_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            rd_count <= 0;
            wr_count <= 0;
            for (int a = 0; a < MEM_BYTES; a++) begin
                ref_mem[a] <= init_byte(12'(a));
            end
        end else begin
            if (mem_resp && mem_read) begin
                rd_count <= rd_count + 1;
            end
            if (mem_resp && mem_write) begin
                wr_count <= wr_count + 1;
            end
            for (int i = 0; i < NUM_CORES; i++) begin
                for (int b = 0; b < MASK_W; b++) begin
                    if (core_resp[i] && core_wmask[i][b]) begin
                        ref_mem[{core_addr[i][11:2], 2'(b)}] <= core_wdata[i][b*8 +: 8];
                    end
                end
            end
        end
    end

    // expected read words, bus line address and the line a write puts on the bus
    always @* begin
        int          owner;
        int          ofs;
        logic [11:0] word_base;
        logic [11:0] line_base;
        cache_addr_t wa;
        owner = 0;
        for (int i = 0; i < NUM_CORES; i++) begin
            word_base = {core_addr[i][11:2], 2'b00};
            for (int b = 0; b < MASK_W; b++) begin
                exp_word[i][b*8 +: 8] = ref_mem[word_base + 12'(b)];
                rd_bits[i][b*8 +: 8] = {8{core_rmask[i][b]}};
            end
            if (UUT.bus_grant[i]) begin
                owner = i;
            end
        end
        // owner's store merged into the owner's line
        wa.raw = core_addr[owner];
        exp_addr = {wa.raw[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        line_base = exp_addr[11:0];
        for (int b = 0; b < LINE_BYTES; b++) begin
            ofs = b - int'(wa.f.word_sel) * MASK_W;
            exp_line[b*8 +: 8] = ref_mem[line_base + 12'(b)];
            if (ofs >= 0 && ofs < MASK_W && core_wmask[owner][ofs]) begin
                exp_line[b*8 +: 8] = core_wdata[owner][ofs*8 +: 8];
            end
        end
    end

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_check
        assert property (@(posedge clk) disable iff (rst)
            core_resp[i] && core_rmask[i] != '0 |-> ((core_rdata[i] ^ exp_word[i]) & rd_bits[i]) == '0)
        else abort_run($sformatf("ERR %0t: core %0d read %h at %h, expected %h",
                                 $time, i, core_rdata[i], core_addr[i], exp_word[i]));
        assert property (@(posedge clk) disable iff (rst)
            core_resp[i] |-> (core_rmask[i] != '0 || core_wmask[i] != '0))
        else abort_run($sformatf("ERR %0t: core %0d responded with no request", $time, i));
    end

    assert property (@(posedge clk) $onehot0(UUT.bus_grant))
    else abort_run($sformatf("ERR %0t: grant %b is not one-hot", $time, UUT.bus_grant));

    assert property (@(posedge clk) disable iff (rst) (mem_read || mem_write) |-> mem_addr == exp_addr)
    else abort_run($sformatf("ERR %0t: bus address %h, expected line %h", $time, mem_addr, exp_addr));

    assert property (@(posedge clk) disable iff (rst) mem_write && mem_resp |-> mem_wdata == exp_line)
    else abort_run($sformatf("ERR %0t: line write at %h carries wrong data", $time, mem_addr));

    assert property (@(posedge clk) rst && $past(rst) |-> core_resp == '0 && !mem_read && !mem_write)
    else abort_run($sformatf("ERR %0t: activity while in reset", $time));

    task automatic access(input int c, input logic [ADDR_W-1:0] addr,
                          input logic [MASK_W-1:0] rmask, input logic [MASK_W-1:0] wmask,
                          input logic [WORD_W-1:0] wdata, output int cycles);
        core_addr[c] = addr;
        core_rmask[c] = rmask;
        core_wmask[c] = wmask;
        core_wdata[c] = wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run($sformatf("core %0d got no response within %0d cycles", c, WAIT_LIMIT));
            end
        end while (!core_resp[c]);
        // request stays up through the response edge
        @(posedge clk);
        #1;
        core_rmask[c] = '0;
        core_wmask[c] = '0;
    endtask

    task automatic expect_traffic(input int rd0, input int wr0, input int drd, input int dwr,
                                  input string what);
        assert (rd_count - rd0 == drd && wr_count - wr0 == dwr)
        else abort_run($sformatf("ERR %0t: %s made %0d reads and %0d writes, expected %0d and %0d",
                                 $time, what, rd_count - rd0, wr_count - wr0, drd, dwr));
    endtask

    task automatic random_traffic(input int c);
        logic [ADDR_W-1:0] addr;
        logic [MASK_W-1:0] mask;
        int                cyc;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            // four lines, all in set 2
            addr = 32'h040 + 32'($urandom_range(3, 0)) * 32'h100 + 32'($urandom_range(7, 0)) * 4;
            mask = 4'($urandom_range(15, 1));
            if ($urandom_range(1, 0) == 0) begin
                access(c, addr, mask, '0, '0, cyc);
            end else begin
                access(c, addr, '0, mask, $urandom, cyc);
            end
        end
    endtask

    initial begin
        int cyc;
        int rd0;
        int wr0;
        int cyc_arr [NUM_CORES];
        void'($urandom(52999));
        rst = 1'b1;
        for (int c = 0; c < NUM_CORES; c++) begin
            core_addr[c] = '0;
            core_rmask[c] = '0;
            core_wmask[c] = '0;
            core_wdata[c] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #1;
            assert (core_resp == '0 && !mem_read && !mem_write)
            else abort_run($sformatf("ERR %0t: bus active with no request", $time));
        end

        // cold miss, then a hit on the same line
        for (int c = 0; c < NUM_CORES; c++) begin
            rd0 = rd_count;
            wr0 = wr_count;
            access(c, 32'h400 + 32'(c * 36), 4'hf, '0, '0, cyc);
            expect_traffic(rd0, wr0, 1, 0, "first read");
            access(c, 32'h400 + 32'(c * 36), 4'h3, '0, '0, cyc);
            expect_traffic(rd0, wr0, 1, 0, "repeat read");
            assert (cyc == 1)
            else abort_run($sformatf("ERR %0t: hit on core %0d took %0d cycles", $time, c, cyc));
        end

        // read-modify-write of a whole line
        rd0 = rd_count;
        wr0 = wr_count;
        access(2, 32'h448, '0, 4'b0110, 32'hc35a_96e1, cyc);
        expect_traffic(rd0, wr0, 1, 1, "write");
        access(2, 32'h448, 4'hf, '0, '0, cyc);
        expect_traffic(rd0, wr0, 1, 1, "read after own write");

        // remote write kills core 1's copy
        access(1, 32'h814, 4'hf, '0, '0, cyc);
        access(0, 32'h814, '0, 4'hf, 32'h0bad_cafe, cyc);
        rd0 = rd_count;
        wr0 = wr_count;
        access(1, 32'h814, 4'hf, '0, '0, cyc);
        expect_traffic(rd0, wr0, 1, 0, "read after remote write");

        // four writers on one word
        rd0 = rd_count;
        wr0 = wr_count;
        fork
            access(0, 32'hc04, '0, 4'b0011, 32'h1111_1111, cyc_arr[0]);
            access(1, 32'hc04, '0, 4'b0110, 32'h2222_2222, cyc_arr[1]);
            access(2, 32'hc04, '0, 4'b1100, 32'h3333_3333, cyc_arr[2]);
            access(3, 32'hc04, '0, 4'b1001, 32'h4444_4444, cyc_arr[3]);
        join
        expect_traffic(rd0, wr0, 4, 4, "contending writes");
        // serialized writes never finish in the same cycle
        for (int a = 0; a < NUM_CORES; a++) begin
            for (int b = a + 1; b < NUM_CORES; b++) begin
                assert (cyc_arr[a] != cyc_arr[b])
                else abort_run($sformatf("ERR %0t: cores %0d and %0d finished writes together",
                                         $time, a, b));
            end
        end
        for (int c = 0; c < NUM_CORES; c++) begin
            access(c, 32'hc04, 4'hf, '0, '0, cyc);
        end

        fork
            random_traffic(0);
            random_traffic(1);
            random_traffic(2);
            random_traffic(3);
        join

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- project.f
hw/cache_geometry_pkg.sv
hw/bus_pkg.sv
hw/snoop_cache.sv
hw/bus_arbiter.sv
hw/coherence_bus.sv
hw/snoop_system_top.sv
bench/line_memory_model.sv
bench/snoop_system_tb.sv

//--- Makefile
TOOL       := verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
TOP        := snoop_system_tb
RTL_TOP    := snoop_system_top
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
